//--- hdl/uart_regs_pkg.sv
/* CSR register map of the serial port. The block answers when address bits
   [13:10] match its select value. Divisor zero is not supported. */
package uart_regs_pkg;

	localparam int CSR_AW = 14;	// CSR address width.
	localparam int CSR_DW = 32;	// CSR data width.
	localparam int SEL_BITS = 4;	// Upper address bits that pick the block.

	localparam int unsigned CLK_FREQ = 100_000_000;	// System clock in Hz.
	localparam int unsigned BAUD = 115_200;	// Line rate after reset.
	localparam logic [15:0] DEFAULT_DIVISOR = 16'(CLK_FREQ / BAUD / 16);	// 16x ticks.

	typedef enum logic [1:0] {
		REG_STAT = 2'd0,	// Status read, acknowledge write.
		REG_DATA = 2'd1,	// Rx byte read, tx byte write.
		REG_DIV = 2'd2	// Baud divisor.
	} csr_reg_e;

	typedef struct packed {
		logic [CSR_AW-1:0] addr;	// Block select and offset.
		logic we;	// Write strobe.
		logic [CSR_DW-1:0] data;	// Write data.
	} csr_req_t;

	// Status image. The zero bits take the acknowledges on a write.
	typedef struct packed {
		logic ack_tx;	// Reads zero, write 1 clears tx_done.
		logic tx_done;	// Frame sent, not yet acknowledged.
		logic tx_busy;	// Frame in progress.
		logic ack_rx;	// Reads zero, write 1 clears rx flags.
		logic rx_error;	// Stop bit was low.
		logic rx_avail;	// Byte waiting.
	} uart_status_t;

endpackage

//--- hdl/uart_line_pkg.sv
/* Serial line definitions for 8N1 frames at 16x oversampling.
   The tick counters assume OVERSAMPLE and DATA_BITS are powers of two. */
package uart_line_pkg;

	localparam int OVERSAMPLE = 16;	// Ticks per bit.
	localparam int DATA_BITS = 8;	// Data bits per frame.
	localparam int OS_W = $clog2(OVERSAMPLE);	// Tick counter width.
	localparam int DB_W = $clog2(DATA_BITS);	// Bit counter width.

	localparam logic [OS_W-1:0] OS_LAST = OS_W'(OVERSAMPLE - 1);	// Last tick of a bit.
	localparam logic [OS_W-1:0] OS_MID = OS_W'(OVERSAMPLE / 2 - 1);	// Mid start bit.
	localparam logic [DB_W-1:0] DB_LAST = DB_W'(DATA_BITS - 1);	// Last data bit.

	typedef enum logic [1:0] {
		RX_IDLE, RX_START, RX_DATA, RX_STOP
	} rx_state_e;

	typedef enum logic [1:0] {
		TX_IDLE, TX_START, TX_DATA, TX_STOP
	} tx_state_e;

	typedef struct packed {
		logic [DATA_BITS-1:0] data;	// Last byte received.
		logic error;	// Framing error flag.
	} rx_result_t;

endpackage

//--- hdl/uart_baud_gen.sv
/* Tick generator at 16x the bit rate. Tick period is divisor cycles.
   A changed divisor applies from the next reload. Divisor zero is not supported. */
`timescale 1ns/1ns

module uart_baud_gen (
	input logic sys_clk,
	input logic sys_rst,
	input logic [15:0] divisor,	// Cycles per tick.
	output logic tick	// One-cycle pulse.
);

	logic [15:0] count;	// Cycles left until the next tick.
	logic reload;	// Count has run out.

	assign reload = (count == 16'd0);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			count <= 16'd0;	// First reload right after reset.
			tick <= 1'b0;
		end else begin
			if (reload) begin
				count <= divisor - 16'd1;	// New divisor picked up here.
				tick <= 1'b1;
			end else begin
				count <= count - 16'd1;
				tick <= 1'b0;
			end
		end
	end

endmodule

//--- hdl/uart_rx.sv
/* 8N1 receiver, 16x oversampled, no parity and no break detection.
   A new frame overwrites an unread byte. rx_ack clears avail and error. */
`timescale 1ns/1ns

module uart_rx
	import uart_line_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst,
	input logic tick,	// 16x bit rate.
	input logic rxd,	// Asynchronous line input.
	input logic rx_ack,	// Clears the flags.
	output rx_result_t rx_result,
	output logic rx_avail
);

	rx_state_e state;
	logic rxd_m;	// First sync stage.
	logic rxd_s;	// Synchronized line.
	logic [OS_W-1:0] cnt;	// Ticks within a bit.
	logic [DB_W-1:0] bit_cnt;	// Data bit index.
	logic [DATA_BITS-1:0] shreg;	// Incoming bits, LSB first.
	logic [DATA_BITS-1:0] rx_data;	// Latched byte.
	logic rx_err;	// Framing error flag.
	logic sample;	// Mid-bit point of a data or stop bit.

	assign sample = tick && (cnt == OS_LAST);
	assign rx_result = '{data: rx_data, error: rx_err};

	// Two-stage synchronizer, idles high.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rxd_m <= 1'b1;
			rxd_s <= 1'b1;
		end else begin
			rxd_m <= rxd;
			rxd_s <= rxd_m;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= RX_IDLE;
			cnt <= '0;
			bit_cnt <= '0;
			rx_avail <= 1'b0;
			rx_err <= 1'b0;
		end else begin
			if (rx_ack) begin	// A frame ending in the same cycle wins below.
				rx_avail <= 1'b0;
				rx_err <= 1'b0;
			end
			if (tick) begin
				case (state)
					RX_IDLE: begin
						if (!rxd_s) begin	// Possible start bit.
							state <= RX_START;
							cnt <= '0;
						end
					end
					RX_START: begin
						cnt <= cnt + 1'b1;
						if (cnt == OS_MID) begin	// Eighth tick, middle of start.
							cnt <= '0;
							bit_cnt <= '0;
							state <= rxd_s ? RX_IDLE : RX_DATA;	// High means glitch.
						end
					end
					RX_DATA: begin
						cnt <= cnt + 1'b1;	// Wraps every 16 ticks.
						if (cnt == OS_LAST) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == DB_LAST)
								state <= RX_STOP;
						end
					end
					RX_STOP: begin
						cnt <= cnt + 1'b1;
						if (cnt == OS_LAST) begin	// Middle of the stop bit.
							rx_avail <= rxd_s;
							rx_err <= !rxd_s;
							state <= RX_IDLE;
						end
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// Byte path.
	always_ff @(posedge sys_clk) begin
		if (sample && state == RX_DATA)
			shreg <= {rxd_s, shreg[DATA_BITS-1:1]};	// LSB arrives first.
		if (sample && state == RX_STOP)
			rx_data <= shreg;	// Latched even on a framing error.
	end

endmodule

//--- hdl/uart_tx.sv
/* 8N1 transmitter. Each bit lasts 16 ticks and the frame starts at the first
   tick after the load. A write while busy is dropped. */
`timescale 1ns/1ns

module uart_tx
	import uart_line_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst,
	input logic tick,	// 16x bit rate.
	input logic tx_wr,	// Load strobe.
	input logic [7:0] tx_data,
	output logic txd,	// Registered line output.
	output logic tx_busy
);

	tx_state_e state;
	logic [OS_W-1:0] cnt;	// Ticks within a bit.
	logic [DB_W-1:0] bit_cnt;	// Data bit index.
	logic [DATA_BITS-1:0] shreg;	// Bits still to send.
	logic bit_start;	// First tick of a bit.
	logic bit_end;	// Last tick of a bit.

	assign bit_start = tick && (cnt == '0);
	assign bit_end = tick && (cnt == OS_LAST);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= TX_IDLE;
			cnt <= '0;
			bit_cnt <= '0;
			txd <= 1'b1;	// Line idles high.
			tx_busy <= 1'b0;
		end else begin
			if (state != TX_IDLE && tick)
				cnt <= cnt + 1'b1;	// Wraps every 16 ticks.
			case (state)
				TX_IDLE: begin
					if (tx_wr) begin
						state <= TX_START;
						cnt <= '0;
						bit_cnt <= '0;
						tx_busy <= 1'b1;
					end
				end
				TX_START: begin
					if (bit_start)
						txd <= 1'b0;
					if (bit_end)
						state <= TX_DATA;
				end
				TX_DATA: begin
					if (bit_start)
						txd <= shreg[0];	// LSB first.
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == DB_LAST)
							state <= TX_STOP;
					end
				end
				TX_STOP: begin
					if (bit_start)
						txd <= 1'b1;
					if (bit_end) begin	// Line stays high until the next start tick.
						state <= TX_IDLE;
						tx_busy <= 1'b0;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Shift register, loaded when idle.
	always_ff @(posedge sys_clk) begin
		if (state == TX_IDLE && tx_wr)
			shreg <= tx_data;
		else if (state == TX_DATA && bit_end)
			shreg <= shreg >> 1;
	end

endmodule

//--- hdl/uart_csr.sv
/* CSR register block of the serial port. Reads are registered, one cycle
   latency, and return zero when the block is not selected. */
`timescale 1ns/1ns

module uart_csr
	import uart_regs_pkg::*;
	import uart_line_pkg::*;
#(
	parameter logic [SEL_BITS-1:0] csr_addr = 4'h0	// Block select value.
) (
	input logic sys_clk,
	input logic sys_rst,
	input csr_req_t csr,	// One bus cycle.
	input rx_result_t rx_result,
	input logic rx_avail,
	input logic tx_busy,
	output logic [CSR_DW-1:0] csr_do,
	output logic [15:0] divisor,
	output logic tx_wr,	// Pulse on a data write.
	output logic [7:0] tx_data,
	output logic rx_ack,	// Pulse on a receive acknowledge.
	output logic rx_irq,
	output logic tx_irq
);

	logic sel;	// Block addressed.
	csr_reg_e reg_sel;	// Register offset.
	logic stat_wr;	// Write to the status register.
	logic tx_ack;	// Transmit acknowledge.
	uart_status_t ack_bits;	// Write data seen as status bits.
	uart_status_t stat;	// Status image.
	logic tx_busy_r;	// Busy one cycle late.
	logic tx_done;

	assign sel = (csr.addr[CSR_AW-1 -: SEL_BITS] == csr_addr);
	assign reg_sel = csr_reg_e'(csr.addr[1:0]);
	assign ack_bits = uart_status_t'(csr.data[$bits(uart_status_t)-1:0]);

	assign stat_wr = sel && csr.we && (reg_sel == REG_STAT);
	assign rx_ack = stat_wr && ack_bits.ack_rx;	// Bit 2.
	assign tx_ack = stat_wr && ack_bits.ack_tx;	// Bit 5.
	assign tx_wr = sel && csr.we && (reg_sel == REG_DATA);
	assign tx_data = csr.data[7:0];

	assign stat = '{
		ack_tx: 1'b0,
		tx_done: tx_done,
		tx_busy: tx_busy,
		ack_rx: 1'b0,
		rx_error: rx_result.error,
		rx_avail: rx_avail
	};

	// Done is set on the falling edge of busy.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			tx_busy_r <= 1'b0;
			tx_done <= 1'b0;
		end else begin
			tx_busy_r <= tx_busy;
			if (tx_ack || tx_wr)
				tx_done <= 1'b0;
			if (tx_busy_r && !tx_busy)	// Set wins over a clear.
				tx_done <= 1'b1;
		end
	end

	// Read mux and divisor register.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
			divisor <= DEFAULT_DIVISOR;
		end else begin
			csr_do <= '0;	// Zero when not selected.
			if (sel) begin
				case (reg_sel)
					REG_STAT: csr_do <= CSR_DW'(stat);
					REG_DATA: csr_do <= CSR_DW'(rx_result.data);
					REG_DIV: csr_do <= CSR_DW'(divisor);
					default: csr_do <= '0;	// Offset 3 is unused.
				endcase
				if (csr.we && reg_sel == REG_DIV)
					divisor <= csr.data[15:0];
			end
		end
	end

	assign rx_irq = rx_avail | rx_result.error;	// Data or error pending.
	assign tx_irq = tx_done;

endmodule

//--- hdl/uart_top.sv
/* Memory-mapped 8N1 serial port with a CSR bus and two interrupt levels.
   No FIFOs, parity or flow control. An unread byte is overwritten. */
`timescale 1ns/1ns

module uart_top
	import uart_regs_pkg::*;
	import uart_line_pkg::*;
#(
	parameter logic [SEL_BITS-1:0] csr_addr = 4'h0	// Block select value.
) (
	input logic sys_clk,
	input logic sys_rst,
	input logic [CSR_AW-1:0] csr_a,
	input logic csr_we,
	input logic [CSR_DW-1:0] csr_di,
	output logic [CSR_DW-1:0] csr_do,
	output logic rx_irq,
	output logic tx_irq,
	input logic uart_rxd,
	output logic uart_txd
);

	csr_req_t csr;	// Bundled bus cycle.
	logic [15:0] divisor;
	logic tick;	// 16x bit rate.
	logic tx_wr;
	logic [7:0] tx_data;
	logic tx_busy;
	logic rx_ack;
	logic rx_avail;
	rx_result_t rx_result;

	assign csr = '{addr: csr_a, we: csr_we, data: csr_di};

	uart_csr #(.csr_addr(csr_addr)) u_csr (
		.sys_clk, .sys_rst, .csr, .rx_result, .rx_avail, .tx_busy,
		.csr_do, .divisor, .tx_wr, .tx_data, .rx_ack, .rx_irq, .tx_irq
	);

	uart_baud_gen u_baud (.sys_clk, .sys_rst, .divisor, .tick);

	uart_rx u_rx (
		.sys_clk, .sys_rst, .tick, .rxd(uart_rxd), .rx_ack, .rx_result, .rx_avail
	);

	uart_tx u_tx (
		.sys_clk, .sys_rst, .tick, .tx_wr, .tx_data, .txd(uart_txd), .tx_busy
	);

endmodule

//--- tests/tb_uart.sv
/* Testbench for uart_top with select value 3 and divisor 2, so a bit lasts 32 cycles.
   Serial frames are driven and decoded at mid-bit by the tasks below. */
`timescale 1ns/1ns

module tb_uart
	import uart_regs_pkg::*;
();

	localparam logic [3:0] SEL = 4'd3;	// Select value of the DUT.
	localparam logic [3:0] OTHER_SEL = 4'd5;	// Some other block.
	localparam int TB_DIV = 2;	// Divisor under test.
	localparam int BIT_CYCLES = 16 * TB_DIV;	// Clock cycles per bit.
	localparam int WAIT_LIMIT = 12 * BIT_CYCLES;	// Longer than a frame.
	localparam int NUM_TESTS = 6;
	localparam logic [31:0] ST_AVAIL = 32'h01;	// Status bits.
	localparam logic [31:0] ST_ERROR = 32'h02;
	localparam logic [31:0] ACK_RX = 32'h04;
	localparam logic [31:0] ST_BUSY = 32'h08;
	localparam logic [31:0] ST_DONE = 32'h10;
	localparam logic [31:0] ACK_TX = 32'h20;

	typedef struct packed {
		logic [7:0] data;	// Byte, unless drawn at random.
		logic is_rx;	// 1 receive, 0 transmit.
		logic bad_stop;	// Low stop bit on receive.
		logic rnd;	// Take an LFSR byte instead.
	} test_entry_t;

	logic sys_clk = 1'b0;
	logic sys_rst = 1'b1;
	logic [13:0] csr_a = '0;
	logic csr_we = 1'b0;
	logic [31:0] csr_di = '0;
	logic uart_rxd = 1'b1;	// Idle line.
	logic [31:0] csr_do;
	logic rx_irq;
	logic tx_irq;
	logic uart_txd;

	test_entry_t tests [NUM_TESTS];
	logic [15:0] lfsr = 16'd47;
	int checks = 0;
	int value_errors = 0;
	int other_errors = 0;	// Timeouts and broken frames.

	always #5 sys_clk = ~sys_clk;

	uart_top #(.csr_addr(SEL)) dut (
		.sys_clk, .sys_rst, .csr_a, .csr_we, .csr_di, .csr_do,
		.rx_irq, .tx_irq, .uart_rxd, .uart_txd
	);

	function automatic logic [13:0] reg_addr(input logic [3:0] sel, input csr_reg_e r);
		return {sel, 8'h00, r};	// Select on top, offset in the low bits.
	endfunction

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);	// Galois, taps 16 14 13 11.
	endfunction

	task automatic next_random_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);	// One step per bit.
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		if (got !== want) begin
			$display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, want);
			value_errors++;
		end
	endtask

	task automatic csr_write(input logic [13:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		csr_a <= addr;
		csr_we <= 1'b1;
		csr_di <= data;
		@(posedge sys_clk);	// DUT takes the write here.
		csr_we <= 1'b0;
	endtask

	task automatic csr_read(input logic [13:0] addr, output logic [31:0] data);
		@(posedge sys_clk);
		csr_a <= addr;
		@(posedge sys_clk);	// Read data registered here.
		@(negedge sys_clk);
		data = csr_do;
	endtask

	// Start bit, data LSB first, stop bit, then one idle bit.
	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		@(posedge sys_clk);
		uart_rxd <= 1'b0;
		repeat (BIT_CYCLES) @(posedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			uart_rxd <= data[i];
			repeat (BIT_CYCLES) @(posedge sys_clk);
		end
		uart_rxd <= stop_bit;
		repeat (BIT_CYCLES) @(posedge sys_clk);
		uart_rxd <= 1'b1;
		repeat (BIT_CYCLES) @(posedge sys_clk);
	endtask

	task automatic monitor_frame(output logic [7:0] data, output logic stop_bit,
			output logic found);
		int n;
		n = 0;
		data = '0;
		stop_bit = 1'b0;
		found = 1'b0;
		while (uart_txd !== 1'b0 && n < WAIT_LIMIT) begin
			@(negedge sys_clk);
			n++;
		end
		if (uart_txd !== 1'b0) begin
			$display("Timeout: no start bit appeared on uart_txd");
			other_errors++;
		end else begin
			found = 1'b1;
			repeat (BIT_CYCLES / 2) @(negedge sys_clk);	// Middle of start bit.
			if (uart_txd !== 1'b0) begin
				$display("Start bit on uart_txd ended before mid-bit");
				other_errors++;
			end
			for (int i = 0; i < 8; i++) begin
				repeat (BIT_CYCLES) @(negedge sys_clk);
				data[i] = uart_txd;
			end
			repeat (BIT_CYCLES) @(negedge sys_clk);
			stop_bit = uart_txd;
		end
	endtask

	task automatic wait_irq(input logic want_rx);
		int n;
		n = 0;
		while ((want_rx ? rx_irq : tx_irq) !== 1'b1 && n < WAIT_LIMIT) begin
			@(negedge sys_clk);
			n++;
		end
		if ((want_rx ? rx_irq : tx_irq) !== 1'b1) begin
			$display("Timeout: %s never went high", want_rx ? "rx_irq" : "tx_irq");
			other_errors++;
		end
	endtask

	task automatic transmit_and_check(input logic [7:0] data);
		logic [31:0] rd;
		logic [7:0] seen;
		logic stop_bit;
		logic found;
		fork
			monitor_frame(seen, stop_bit, found);
			begin
				csr_write(reg_addr(SEL, REG_DATA), 32'(data));
				csr_read(reg_addr(SEL, REG_STAT), rd);
				compare_value("csr_do status while sending", rd, ST_BUSY);
			end
		join
		if (found) begin
			compare_value("uart_txd data", 32'(seen), 32'(data));
			compare_value("uart_txd stop bit", 32'(stop_bit), 32'h1);
		end
		wait_irq(1'b0);
		csr_read(reg_addr(SEL, REG_STAT), rd);
		compare_value("csr_do status after send", rd, ST_DONE);
		compare_value("tx_irq", 32'(tx_irq), 32'h1);
		csr_write(reg_addr(SEL, REG_STAT), ACK_TX);
		csr_read(reg_addr(SEL, REG_STAT), rd);
		compare_value("csr_do status after tx ack", rd, 32'h0);
		compare_value("tx_irq after ack", 32'(tx_irq), 32'h0);
	endtask

	task automatic receive_and_check(input logic [7:0] data, input logic bad_stop);
		logic [31:0] rd;
		send_frame(data, !bad_stop);
		wait_irq(1'b1);
		csr_read(reg_addr(SEL, REG_STAT), rd);
		compare_value("csr_do status after receive", rd, bad_stop ? ST_ERROR : ST_AVAIL);
		compare_value("rx_irq", 32'(rx_irq), 32'h1);
		if (!bad_stop) begin
			csr_read(reg_addr(SEL, REG_DATA), rd);
			compare_value("csr_do rx data", rd, 32'(data));
		end
		csr_write(reg_addr(SEL, REG_STAT), ACK_RX);
		csr_read(reg_addr(SEL, REG_STAT), rd);
		compare_value("csr_do status after rx ack", rd, 32'h0);
		compare_value("rx_irq after ack", 32'(rx_irq), 32'h0);
	endtask

	initial begin
		logic [31:0] rd;
		logic [7:0] first_byte;
		logic [7:0] second_byte;
		tests[0] = '{data: 8'h55, is_rx: 1'b0, bad_stop: 1'b0, rnd: 1'b0};
		tests[1] = '{data: 8'h00, is_rx: 1'b0, bad_stop: 1'b0, rnd: 1'b1};
		tests[2] = '{data: 8'h3C, is_rx: 1'b1, bad_stop: 1'b0, rnd: 1'b0};
		tests[3] = '{data: 8'h00, is_rx: 1'b1, bad_stop: 1'b0, rnd: 1'b1};
		tests[4] = '{data: 8'hA5, is_rx: 1'b1, bad_stop: 1'b1, rnd: 1'b0};
		tests[5] = '{data: 8'h00, is_rx: 1'b0, bad_stop: 1'b0, rnd: 1'b1};
		for (int k = 0; k < NUM_TESTS; k++) begin
			if (tests[k].rnd) begin
				next_random_byte(first_byte);
				tests[k].data = first_byte;
			end
		end

		repeat (8) @(posedge sys_clk);
		sys_rst <= 1'b0;
		@(negedge sys_clk);
		compare_value("csr_do after reset", csr_do, 32'h0);
		compare_value("rx_irq after reset", 32'(rx_irq), 32'h0);
		compare_value("tx_irq after reset", 32'(tx_irq), 32'h0);
		compare_value("uart_txd after reset", 32'(uart_txd), 32'h1);
		csr_read(reg_addr(SEL, REG_STAT), rd);
		compare_value("csr_do status after reset", rd, 32'h0);
		csr_read(reg_addr(SEL, REG_DIV), rd);
		compare_value("csr_do divisor after reset", rd, 32'(DEFAULT_DIVISOR));

		csr_write(reg_addr(SEL, REG_DIV), 32'(TB_DIV));
		csr_read(reg_addr(SEL, REG_DIV), rd);
		compare_value("csr_do divisor", rd, 32'(TB_DIV));
		csr_write(reg_addr(OTHER_SEL, REG_DIV), 32'h0000_0007);	// Not for this block.
		csr_read(reg_addr(SEL, REG_DIV), rd);
		compare_value("csr_do divisor after foreign write", rd, 32'(TB_DIV));
		csr_read(reg_addr(OTHER_SEL, REG_DIV), rd);
		compare_value("csr_do foreign read", rd, 32'h0);

		for (int k = 0; k < NUM_TESTS; k++) begin
			if (tests[k].is_rx)
				receive_and_check(tests[k].data, tests[k].bad_stop);
			else
				transmit_and_check(tests[k].data);
		end

		next_random_byte(first_byte);	// Second frame lands on an unread first.
		next_random_byte(second_byte);
		send_frame(first_byte, 1'b1);
		send_frame(second_byte, 1'b1);
		wait_irq(1'b1);
		csr_read(reg_addr(SEL, REG_DATA), rd);
		compare_value("csr_do rx data after overwrite", rd, 32'(second_byte));
		csr_read(reg_addr(SEL, REG_STAT), rd);
		compare_value("csr_do status after overwrite", rd, ST_AVAIL);
		csr_write(reg_addr(SEL, REG_STAT), ACK_RX);

		$display("Checks run: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- sources.f
hdl/uart_regs_pkg.sv
hdl/uart_line_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_csr.sv
hdl/uart_top.sv
tests/tb_uart.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --timescale 1ns/1ns -j 0
TOP ?= tb_uart
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
PASS_MSG := All checks passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee /dev/stderr | grep -Fx "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
